/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
    --top-module mips_cpu_tb -o mips_cpu_sim > build.log 2>&1 \
    && ./obj_dir/mips_cpu_sim > sim.log 2>&1
grep -q '^Testbench passed$' sim.log \
    && echo "run: PASS" \
    || { cat build.log sim.log 2>/dev/null; echo "run: FAIL"; exit 1; }

/* sim.f */
src/mips_pkg.sv
src/mips_decoder.sv
src/mips_control_fsm.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_datapath.sv
src/mips_cpu_top.sv
tb/mips_cpu_asserts.sv
tb/mips_cpu_tb.sv

/* src/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   result
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOR: result = ~(a | b);
            // compares give 1 or 0
            ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {31'd0, a < b};
            end
            default: result = '0;
        endcase
    end

endmodule

/* src/mips_control_fsm.sv */
`timescale 1ns/1ps

module mips_control_fsm (
    input  logic                 clk,
    input  logic                 resetn,
    input  mips_pkg::ins_class_t ins_class,
    input  logic [5:0]           opcode,
    input  logic                 zero,
    output mips_pkg::cpu_state_t state,
    output logic                 rf_wr,
    output logic                 pc_wr,
    output logic                 taken
);
    import mips_pkg::*;

    cpu_state_t state_next;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            state <= ST_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = ST_FETCH;
        case (state)
            ST_FETCH: state_next = ST_DECODE;
            ST_DECODE: begin
                if (ins_class == CLS_LUI) begin
                    state_next = ST_WRITE_BACK;
                end else if (ins_class != CLS_NOP) begin
                    state_next = ST_EXECUTE;
                end
            end
            ST_EXECUTE: begin
                case (ins_class)
                    CLS_LOAD:                state_next = ST_MEM_READ;
                    CLS_STORE:               state_next = ST_MEM_WRITE;
                    CLS_ALU_REG, CLS_ALU_IMM: state_next = ST_WRITE_BACK;
                    default:                 state_next = ST_FETCH;
                endcase
            end
            ST_MEM_READ: state_next = ST_WRITE_BACK;
            default: state_next = ST_FETCH;
        endcase
    end

    // strobes for the last state of each instruction
    always_comb begin
        rf_wr = (state == ST_WRITE_BACK);
        taken = 1'b0;
        case (state)
            ST_DECODE:     pc_wr = (ins_class == CLS_NOP);
            ST_EXECUTE:    pc_wr = (ins_class == CLS_BRANCH) || (ins_class == CLS_JUMP);
            ST_MEM_WRITE:  pc_wr = 1'b1;
            ST_WRITE_BACK: pc_wr = 1'b1;
            default:       pc_wr = 1'b0;
        endcase
        // beq takes on equal operands, bne on different ones
        if (state == ST_EXECUTE && ins_class == CLS_BRANCH) begin
            taken = (opcode == OP_BNE) ? !zero : zero;
        end
    end

endmodule

/* src/mips_cpu_top.sv */
`timescale 1ns/1ps

module mips_cpu_top #(
    parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                resetn,
    output mips_pkg::word_t     inst_sram_addr,
    input  mips_pkg::word_t     inst_sram_rdata,
    output logic                data_sram_en,
    output logic                data_sram_wen,
    output mips_pkg::word_t     data_sram_addr,
    output mips_pkg::word_t     data_sram_wdata,
    input  mips_pkg::word_t     data_sram_rdata,
    output mips_pkg::word_t     debug_wb_pc,
    output logic                debug_wb_rf_wen,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t     debug_wb_rf_wdata
);
    import mips_pkg::*;

    instr_t     ins;
    ins_class_t ins_class;
    alu_op_t    alu_op;
    cpu_state_t state;
    logic       use_imm;
    logic       sign_ext;
    logic       rf_wr;
    logic       pc_wr;
    logic       taken;
    logic       zero;
    word_t      pc;

    // sram read data holds the word of the current pc from decode on
    assign ins = inst_sram_rdata;

    mips_decoder i_decoder (
        .ins       (ins),
        .ins_class (ins_class),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .sign_ext  (sign_ext)
    );

    mips_control_fsm i_control_fsm (
        .clk       (clk),
        .resetn    (resetn),
        .ins_class (ins_class),
        .opcode    (ins.i_view.opcode),
        .zero      (zero),
        .state     (state),
        .rf_wr     (rf_wr),
        .pc_wr     (pc_wr),
        .taken     (taken)
    );

    mips_datapath #(
        .RESET_PC (RESET_PC)
    ) i_datapath (
        .clk          (clk),
        .resetn       (resetn),
        .ins          (ins),
        .state        (state),
        .ins_class    (ins_class),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .sign_ext     (sign_ext),
        .rf_wr        (rf_wr),
        .pc_wr        (pc_wr),
        .taken        (taken),
        .mem_rdata    (data_sram_rdata),
        .pc           (pc),
        .alu_result_q (data_sram_addr),
        .store_data   (data_sram_wdata),
        .wb_data      (debug_wb_rf_wdata),
        .wb_addr      (debug_wb_rf_wnum),
        .zero         (zero)
    );

    assign inst_sram_addr  = pc;
    assign data_sram_en    = (state == ST_MEM_READ) || (state == ST_MEM_WRITE);
    assign data_sram_wen   = (state == ST_MEM_WRITE);
    assign debug_wb_pc     = pc;
    assign debug_wb_rf_wen = rf_wr;

endmodule

/* src/mips_datapath.sv */
`timescale 1ns/1ps

module mips_datapath #(
    parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  mips_pkg::instr_t     ins,
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::ins_class_t ins_class,
    input  mips_pkg::alu_op_t    alu_op,
    input  logic                 use_imm,
    input  logic                 sign_ext,
    input  logic                 rf_wr,
    input  logic                 pc_wr,
    input  logic                 taken,
    input  mips_pkg::word_t      mem_rdata,
    output mips_pkg::word_t      pc,
    output mips_pkg::word_t      alu_result_q,
    output mips_pkg::word_t      store_data,
    output mips_pkg::word_t      wb_data,
    output mips_pkg::reg_addr_t  wb_addr,
    output logic                 zero
);
    import mips_pkg::*;

    word_t rd_data1;
    word_t rd_data2;
    word_t a_q;
    word_t b_q;
    word_t imm_ext;
    word_t alu_b;
    word_t alu_y;
    word_t pc_plus4;
    word_t next_pc;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            pc <= RESET_PC;
        end else if (pc_wr) begin
            pc <= next_pc;
        end
    end

    // operands latched leaving decode, result leaving execute
    always_ff @(posedge clk) begin
        if (state == ST_DECODE) begin
            a_q <= rd_data1;
            b_q <= rd_data2;
        end
        if (state == ST_EXECUTE) begin
            alu_result_q <= alu_y;
        end
    end

    mips_regfile i_regfile (
        .clk      (clk),
        .resetn   (resetn),
        .rd_addr1 (ins.r_view.rs),
        .rd_addr2 (ins.r_view.rt),
        .wr_addr  (wb_addr),
        .wr_en    (rf_wr),
        .wr_data  (wb_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    assign imm_ext = sign_ext ? {{16{ins.i_view.imm[15]}}, ins.i_view.imm}
                              : {16'd0, ins.i_view.imm};
    assign alu_b   = use_imm ? imm_ext : b_q;

    mips_alu i_alu (
        .a      (a_q),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_y)
    );

    // branch decision needs the unregistered result
    assign zero       = (alu_y == '0);
    assign store_data = b_q;

    assign pc_plus4 = pc + 32'd4;
    always_comb begin
        if (ins_class == CLS_JUMP) begin
            // j target keeps the upper region of pc+4
            next_pc = {pc_plus4[31:28], ins[25:0], 2'b00};
        end else if (taken) begin
            next_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign wb_addr = (ins_class == CLS_ALU_REG) ? ins.r_view.rd : ins.r_view.rt;

    always_comb begin
        case (ins_class)
            CLS_LOAD: wb_data = mem_rdata;
            CLS_LUI:  wb_data = {ins.i_view.imm, 16'd0};
            default:  wb_data = alu_result_q;
        endcase
    end

endmodule

/* src/mips_decoder.sv */
`timescale 1ns/1ps

module mips_decoder (
    input  mips_pkg::instr_t     ins,
    output mips_pkg::ins_class_t ins_class,
    output mips_pkg::alu_op_t    alu_op,
    output logic                 use_imm,
    output logic                 sign_ext
);
    import mips_pkg::*;

    always_comb begin
        ins_class = CLS_NOP;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        sign_ext  = 1'b1;
        case (ins.i_view.opcode)
            OP_SPECIAL: begin
                // only plain register ops, shamt must be zero
                if (ins.r_view.shamt == 5'd0) begin
                    ins_class = CLS_ALU_REG;
                    case (ins.r_view.funct)
                        FN_ADDU: alu_op = ALU_ADD;
                        FN_SUBU: alu_op = ALU_SUB;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_XOR:  alu_op = ALU_XOR;
                        FN_NOR:  alu_op = ALU_NOR;
                        FN_SLT:  alu_op = ALU_SLT;
                        FN_SLTU: alu_op = ALU_SLTU;
                        default: ins_class = CLS_NOP;
                    endcase
                end
            end
            OP_ADDIU: begin
                ins_class = CLS_ALU_IMM;
                use_imm   = 1'b1;
            end
            OP_SLTI: begin
                ins_class = CLS_ALU_IMM;
                alu_op    = ALU_SLT;
                use_imm   = 1'b1;
            end
            OP_SLTIU: begin
                ins_class = CLS_ALU_IMM;
                alu_op    = ALU_SLTU;
                use_imm   = 1'b1;
            end
            // logic immediates are zero extended
            OP_ANDI: begin
                ins_class = CLS_ALU_IMM;
                alu_op    = ALU_AND;
                use_imm   = 1'b1;
                sign_ext  = 1'b0;
            end
            OP_ORI: begin
                ins_class = CLS_ALU_IMM;
                alu_op    = ALU_OR;
                use_imm   = 1'b1;
                sign_ext  = 1'b0;
            end
            OP_XORI: begin
                ins_class = CLS_ALU_IMM;
                alu_op    = ALU_XOR;
                use_imm   = 1'b1;
                sign_ext  = 1'b0;
            end
            OP_LUI: ins_class = CLS_LUI;
            OP_LW: begin
                ins_class = CLS_LOAD;
                use_imm   = 1'b1;
            end
            OP_SW: begin
                ins_class = CLS_STORE;
                use_imm   = 1'b1;
            end
            // compare by subtraction
            OP_BEQ, OP_BNE: begin
                ins_class = CLS_BRANCH;
                alu_op    = ALU_SUB;
            end
            OP_J: ins_class = CLS_JUMP;
            default: ins_class = CLS_NOP;
        endcase
    end

endmodule

/* src/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // register format view
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // immediate format view
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
    } instr_t;

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // function field of OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [2:0] {
        CLS_ALU_REG, CLS_ALU_IMM, CLS_LUI, CLS_LOAD,
        CLS_STORE, CLS_BRANCH, CLS_JUMP, CLS_NOP
    } ins_class_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_EXECUTE,
        ST_MEM_READ, ST_MEM_WRITE, ST_WRITE_BACK
    } cpu_state_t;

endpackage

/* src/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
    input  logic                clk,
    input  logic                resetn,
    input  mips_pkg::reg_addr_t rd_addr1,
    input  mips_pkg::reg_addr_t rd_addr2,
    input  mips_pkg::reg_addr_t wr_addr,
    input  logic                wr_en,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rd_data1,
    output mips_pkg::word_t     rd_data2
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // $0 never written, so it stays zero
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

/* tb/mips_cpu_asserts.sv */
`timescale 1ns/1ps

module mips_cpu_asserts (
    input logic            clk,
    input logic            resetn,
    input mips_pkg::word_t inst_sram_addr,
    input logic            data_sram_en,
    input logic            data_sram_wen,
    input logic            debug_wb_rf_wen
);

    wen_needs_en: assert property (@(posedge clk) disable iff (resetn)
        data_sram_wen |-> data_sram_en)
        else $error("data write enable without data enable");

    // fetch addresses are whole words
    pc_aligned: assert property (@(posedge clk) disable iff (resetn)
        inst_sram_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    no_wb_in_reset: assert property (@(posedge clk) resetn |-> !debug_wb_rf_wen)
        else $error("register write during reset");

    no_wb_after_reset: assert property (@(posedge clk) $past(resetn) |-> !debug_wb_rf_wen)
        else $error("register write in the first cycle after reset");

endmodule

bind mips_cpu_top mips_cpu_asserts i_asserts (
    .clk             (clk),
    .resetn          (resetn),
    .inst_sram_addr  (inst_sram_addr),
    .data_sram_en    (data_sram_en),
    .data_sram_wen   (data_sram_wen),
    .debug_wb_rf_wen (debug_wb_rf_wen)
);

/* tb/mips_cpu_tb.sv */
`timescale 1ns/1ps

module mips_cpu_tb;
    import mips_pkg::*;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t HALT_PC  = 32'd180;
    localparam int    MAX_WAIT = 20;
    localparam int    EV_NONE  = 0;
    localparam int    EV_WB    = 1;
    localparam int    EV_STORE = 2;

    logic      clk = 1'b0;
    logic      resetn;
    word_t     inst_sram_addr;
    word_t     inst_sram_rdata = '0;
    logic      data_sram_en;
    logic      data_sram_wen;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    word_t     data_sram_rdata = '0;
    word_t     debug_wb_pc;
    logic      debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    integer seed = 43672;
    word_t  imem [256];
    word_t  dmem [256];
    // shadow state of the reference model
    word_t  ref_mem [256];
    word_t  ref_regs [32];
    word_t  ref_pc;
    word_t  i_word;
    word_t  d_word;
    logic   d_rd;

    always #2 clk = ~clk;

    mips_cpu_top #(
        .RESET_PC (RESET_PC)
    ) i_mips_cpu_top (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // both srams answer one cycle after the address
    always @(posedge clk) begin
        i_word = imem[inst_sram_addr[9:2]];
        d_rd = data_sram_en && !data_sram_wen;
        if (data_sram_en && data_sram_wen) begin
            dmem[data_sram_addr[9:2]] = data_sram_wdata;
        end
        d_word = dmem[data_sram_addr[9:2]];
        #0.5;
        inst_sram_rdata = i_word;
        if (d_rd) begin
            data_sram_rdata = d_word;
        end
    end

    function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs,
                                    input int rt);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    // assembly order: op rt, rs, imm
    function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs,
                                    input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t enc_j(input int target);
        return {OP_J, target[25:0]};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        imem[0]  = enc_i(OP_LW, 1, 0, 0);
        imem[1]  = enc_i(OP_LW, 2, 0, 4);
        imem[2]  = enc_i(OP_LW, 3, 0, 8);
        imem[3]  = enc_r(FN_ADDU, 4, 1, 2);
        imem[4]  = enc_r(FN_SUBU, 5, 1, 2);
        imem[5]  = enc_r(FN_AND, 6, 1, 2);
        imem[6]  = enc_r(FN_OR, 7, 1, 3);
        imem[7]  = enc_r(FN_XOR, 8, 2, 3);
        imem[8]  = enc_r(FN_NOR, 9, 1, 3);
        imem[9]  = enc_r(FN_SLT, 10, 1, 2);
        imem[10] = enc_r(FN_SLTU, 11, 1, 2);
        imem[11] = enc_r(FN_SLT, 12, 2, 3);
        imem[12] = enc_r(FN_SLTU, 13, 3, 1);
        imem[13] = enc_i(OP_ADDIU, 14, 1, 'h8001);
        imem[14] = enc_i(OP_ANDI, 15, 1, 'hf0f0);
        imem[15] = enc_i(OP_ORI, 16, 2, 'h8000);
        imem[16] = enc_i(OP_XORI, 17, 3, 'hffff);
        imem[17] = enc_i(OP_SLTI, 18, 1, 'hffff);
        imem[18] = enc_i(OP_SLTIU, 19, 2, 'h8000);
        imem[19] = enc_i(OP_LUI, 20, 0, 'hdead);
        imem[20] = enc_i(OP_ORI, 20, 20, 'hbeef);
        imem[21] = enc_i(OP_ADDIU, 21, 0, 'h100);
        imem[22] = enc_i(OP_SW, 4, 21, 'h10);
        imem[23] = enc_i(OP_SW, 5, 21, -8);
        imem[24] = enc_i(OP_LW, 22, 21, 'h10);
        imem[25] = enc_i(OP_LW, 23, 21, -8);
        imem[26] = enc_i(OP_LW, 24, 0, 'h20);
        imem[27] = enc_i(OP_LW, 25, 0, 'h3fc);
        // imem[28] stays all zero
        imem[29] = enc_r(FN_ADDU, 0, 1, 2);
        imem[30] = enc_r(FN_ADDU, 26, 0, 1);
        imem[31] = enc_i(OP_BEQ, 1, 1, 2);
        imem[32] = enc_i(OP_ADDIU, 27, 0, 1);
        imem[33] = enc_i(OP_ADDIU, 27, 0, 2);
        imem[34] = enc_i(OP_BNE, 1, 1, 5);
        imem[35] = enc_i(OP_BNE, 2, 1, 1);
        imem[36] = enc_i(OP_ADDIU, 27, 0, 3);
        imem[37] = enc_i(OP_BEQ, 2, 1, 1);
        imem[38] = enc_i(OP_ADDIU, 28, 0, 4);
        imem[39] = enc_j(42);
        imem[40] = enc_i(OP_ADDIU, 29, 0, 5);
        // short loop, backward branch runs three times
        imem[42] = enc_i(OP_ADDIU, 30, 30, 1);
        imem[43] = enc_i(OP_SLTI, 31, 30, 3);
        imem[44] = enc_i(OP_BNE, 0, 31, -3);
        imem[45] = enc_j(45);
    endtask

    // executes the instruction at ref_pc, returns the kind of visible event
    function automatic int ref_step(output word_t ev_pc, output word_t ev_tag,
                                    output word_t ev_data);
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      se;
        word_t      ze;
        word_t      res;
        word_t      addr;
        word_t      npc;
        logic [4:0] dst;
        int         kind;
        ins = imem[ref_pc[9:2]];
        a = ref_regs[ins[25:21]];
        b = ref_regs[ins[20:16]];
        se = {{16{ins[15]}}, ins[15:0]};
        ze = {16'd0, ins[15:0]};
        addr = a + se;
        npc = ref_pc + 32'd4;
        dst = ins[20:16];
        res = '0;
        kind = EV_WB;
        case (ins[31:26])
            OP_SPECIAL: begin
                dst = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    default: kind = EV_NONE;
                endcase
                if (ins[10:6] != 5'd0) begin
                    kind = EV_NONE;
                end
            end
            OP_ADDIU: res = a + se;
            OP_SLTI:  res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < se) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & ze;
            OP_ORI:   res = a | ze;
            OP_XORI:  res = a ^ ze;
            OP_LUI:   res = {ins[15:0], 16'd0};
            OP_LW:    res = ref_mem[addr[9:2]];
            OP_SW: begin
                ref_mem[addr[9:2]] = b;
                kind = EV_STORE;
            end
            OP_BEQ: begin
                kind = EV_NONE;
                if (a == b) begin
                    npc = npc + {se[29:0], 2'b00};
                end
            end
            OP_BNE: begin
                kind = EV_NONE;
                if (a != b) begin
                    npc = npc + {se[29:0], 2'b00};
                end
            end
            OP_J: begin
                kind = EV_NONE;
                npc = {npc[31:28], ins[25:0], 2'b00};
            end
            default: kind = EV_NONE;
        endcase
        if (kind == EV_WB && dst != 5'd0) begin
            ref_regs[dst] = res;
        end
        ev_pc = ref_pc;
        ev_tag = (kind == EV_STORE) ? addr : {27'd0, dst};
        ev_data = (kind == EV_STORE) ? b : res;
        ref_pc = npc;
        return kind;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    // waits for the next register write or store
    task automatic wait_event();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!debug_wb_rf_wen && !data_sram_wen && cycles < MAX_WAIT);
        if (!debug_wb_rf_wen && !data_sram_wen) begin
            report_failure("processor stopped writing back within 20 cycles");
        end
    endtask

    task automatic compare_event(input int kind, input word_t exp_pc, input word_t exp_tag,
                                 input word_t exp_data);
        check_value($sformatf("event type at pc %h", exp_pc), kind,
                    debug_wb_rf_wen ? EV_WB : EV_STORE);
        if (kind == EV_WB) begin
            check_value($sformatf("wb pc at pc %h", exp_pc), exp_pc, debug_wb_pc);
            check_value($sformatf("wb reg at pc %h", exp_pc), exp_tag,
                        {27'd0, debug_wb_rf_wnum});
            check_value($sformatf("wb data at pc %h", exp_pc), exp_data, debug_wb_rf_wdata);
        end else begin
            check_value($sformatf("store addr at pc %h", exp_pc), exp_tag, data_sram_addr);
            check_value($sformatf("store data at pc %h", exp_pc), exp_data, data_sram_wdata);
        end
    endtask

    initial begin
        int    kind;
        int    steps;
        word_t exp_pc;
        word_t exp_tag;
        word_t exp_data;
        resetn = 1'b1;
        load_program();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $random(seed);
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc = RESET_PC;
        repeat (4) @(posedge clk);
        #0.5;
        resetn = 1'b0;

        while (ref_pc != HALT_PC) begin
            kind = EV_NONE;
            steps = 0;
            while (kind == EV_NONE && ref_pc != HALT_PC && steps < 64) begin
                kind = ref_step(exp_pc, exp_tag, exp_data);
                steps++;
            end
            if (kind != EV_NONE) begin
                wait_event();
                compare_event(kind, exp_pc, exp_tag, exp_data);
            end else if (ref_pc != HALT_PC) begin
                report_failure("reference model found no write in 64 instructions");
            end
        end

        // the final jump loops on itself and must stay silent
        for (int i = 0; i < MAX_WAIT; i++) begin
            @(negedge clk);
            if (debug_wb_rf_wen || data_sram_wen) begin
                report_failure("write seen after the program reached its final jump");
            end
            check_value("data enable after final jump", 32'd0, {31'd0, data_sram_en});
        end
        check_value("pc held by final jump", HALT_PC, inst_sram_addr);
        $display("Testbench passed");
        $finish;
    end

endmodule
